// ==== Makefile ====
TOP := sd_init_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG) || ! grep -q "Finished with no errors" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@echo "simulation passed"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// ==== design/card_regs.sv ====
`include "sd_init_consts.svh"

module card_regs (
    input  logic                       ex_clk,
    input  logic                       reset,
    input  sd_init_pkg::response_t     response,
    input  logic                       load_cid,
    input  logic                       load_rca,
    input  logic                       load_r1_status,
    input  logic                       load_r6_status,
    output sd_init_pkg::cid_t          cid,
    output sd_init_pkg::rca_t          rca,
    output sd_init_pkg::card_status_t  card_status
);
    import sd_init_pkg::*;

    card_status_t payload;
    card_status_t r6_status;

    assign payload = response[`SD_PAY_MSB:`SD_PAY_LSB];

    // R6 packs a short status into payload bits 15..0
    always_comb begin
        r6_status       = '0;
        r6_status[23]   = payload[15];
        r6_status[22]   = payload[14];
        r6_status[19]   = payload[13];
        r6_status[12:0] = payload[12:0];
    end

    always_ff @(posedge ex_clk or posedge reset) begin
        if (reset) begin
            cid         <= '0;
            rca         <= '0;   // default address until CMD3
            card_status <= '0;
        end else begin
            if (load_cid) cid <= response;
            if (load_rca) rca <= payload[31:16];
            if (load_r6_status) begin
                card_status <= r6_status;
            end else if (load_r1_status) begin
                card_status <= payload;
            end
        end
    end

endmodule

// ==== design/gap_timeout_timer.sv ====
`include "sd_init_consts.svh"

module gap_timeout_timer (
    input  logic                      ex_clk,
    input  logic                      reset,
    input  sd_init_pkg::timer_mode_t  timer_mode,
    input  logic                      sd_receive_started,
    output logic                      timed_out,
    output logic                      gap_done
);
    import sd_init_pkg::*;

    logic [`SD_TIMER_W-1:0] count;

    always_ff @(posedge ex_clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else begin
            case (timer_mode)
                timer_listen: begin
                    if (sd_receive_started) begin
                        count <= '0;                  // line active again
                    end else if (count != `SD_TIMEOUT_LIMIT) begin
                        count <= count + 1'b1;
                    end
                end
                timer_gap: begin
                    if (!gap_done) count <= count + 1'b1;
                end
                default: count <= '0;
            endcase
        end
    end

    assign timed_out = (timer_mode == timer_listen) && (count == `SD_TIMEOUT_LIMIT);

    // gap state lasts SD_GAP_CYCLES cycles in total
    assign gap_done = (timer_mode == timer_gap) && (count == `SD_GAP_CYCLES - 1'b1);

endmodule

// ==== design/response_checker.sv ====
`include "sd_init_consts.svh"

module response_checker (
    input  sd_init_pkg::response_t   response,
    input  sd_init_pkg::resp_kind_t  resp_kind,
    output logic                     resp_ok,
    output logic                     card_busy,
    output logic                     volt_bad
);
    import sd_init_pkg::*;

    cmd_index_t   echo_idx;
    card_status_t payload;

    assign echo_idx = response[`SD_IDX_MSB:`SD_IDX_LSB];
    assign payload  = response[`SD_PAY_MSB:`SD_PAY_LSB];

    always_comb begin
        resp_ok   = 1'b0;
        card_busy = 1'b0;
        volt_bad  = 1'b0;
        case (resp_kind)
            resp_r1: begin
                // only CMD55 expects R1 during identification
                resp_ok = (echo_idx == `SD_CMD55) &&
                          ((payload & `SD_R1_ERR_MASK) == 32'h0);
            end
            resp_r2: resp_ok = 1'b1;   // CID, nothing to judge
            resp_r3: begin
                card_busy = payload[`SD_OCR_BUSY_BIT];
                volt_bad  = |payload[`SD_VOLT_MSB:`SD_VOLT_LSB];
                resp_ok   = !card_busy && !volt_bad;
            end
            resp_r6: begin
                // seven status error bits above the LSB
                resp_ok = ~|payload[`SD_R6_ERR_LSB +: 7];
            end
            default: ;
        endcase
    end

endmodule

// ==== design/sd_init_consts.svh ====
`ifndef SD_INIT_CONSTS_SVH
`define SD_INIT_CONSTS_SVH

// command indices
`define SD_CMD0           6'd0
`define SD_CMD2           6'd2
`define SD_CMD3           6'd3
`define SD_CMD55          6'd55
`define SD_ACMD41         6'd41

// cycle counts, sized to the timer counter
`define SD_TIMER_W        4
`define SD_GAP_CYCLES     4'd8
`define SD_TIMEOUT_LIMIT  4'd5

// response word layout
`define SD_IDX_MSB        124
`define SD_IDX_LSB        119
`define SD_PAY_MSB        118
`define SD_PAY_LSB        87

// payload fields
`define SD_R1_ERR_MASK    32'hFFF8_0000   // card status bits 31..19
`define SD_R6_ERR_LSB     9               // seven error bits, 15..9
`define SD_OCR_BUSY_BIT   31
`define SD_VOLT_MSB       21
`define SD_VOLT_LSB       20

`endif

// ==== design/sd_init_fsm.sv ====
`include "sd_init_consts.svh"

module sd_init_fsm (
    input  logic                       ex_clk,
    input  logic                       reset,
    input  logic                       sd_cd_pin,
    input  logic                       sd_sending,
    input  logic                       sd_send_finished,
    input  logic                       sd_receive_started,
    input  logic                       sd_receive_finished,
    input  logic                       crc_loaded,
    input  logic                       crc_response_err,
    input  logic                       timed_out,
    input  logic                       gap_done,
    input  logic                       resp_ok,
    input  logic                       card_busy,
    input  logic                       volt_bad,
    input  sd_init_pkg::rca_t          rca,
    input  sd_init_pkg::card_status_t  host_ocr,
    output logic                       send_en,
    output sd_init_pkg::cmd_frame_t    send_cmd_content,
    output logic                       receive_en,
    output logic                       r2_response,
    output logic                       r3_response,
    output logic                       init_done,
    output logic                       init_failed,
    output sd_init_pkg::resp_kind_t    resp_kind,
    output sd_init_pkg::timer_mode_t   timer_mode,
    output logic                       load_cid,
    output logic                       load_rca,
    output logic                       load_r1_status,
    output logic                       load_r6_status
);
    import sd_init_pkg::*;

    init_state_t state;
    init_state_t next_state;
    cmd_index_t  cmd_idx;
    cmd_arg_t    cmd_arg;
    logic        rx_done;

    // R3 carries no CRC, so its end is the receiver's finish flag
    assign rx_done = (resp_kind == resp_r3) ? sd_receive_finished : crc_loaded;

    always_ff @(posedge ex_clk or posedge reset) begin
        if (reset) begin
            state <= st_wait_card;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state     = state;
        receive_en     = 1'b0;
        load_cid       = 1'b0;
        load_rca       = 1'b0;
        load_r1_status = 1'b0;
        load_r6_status = 1'b0;
        case (state)
            st_wait_card: if (sd_cd_pin) next_state = st_cmd55_send;
            st_cmd55_send, st_acmd41_send, st_cmd2_send, st_cmd3_send: begin
                if (sd_sending) next_state = init_state_t'(state + 5'd1);
            end
            st_cmd55_wait, st_acmd41_wait, st_cmd2_wait, st_cmd3_wait: begin
                if (sd_send_finished) begin
                    receive_en = 1'b1;              // one cycle only
                    next_state = init_state_t'(state + 5'd1);
                end
            end
            st_cmd55_receive, st_acmd41_receive, st_cmd2_receive, st_cmd3_receive: begin
                if (rx_done) begin
                    next_state = init_state_t'(state + 5'd1);
                end else if (timed_out && !sd_receive_started) begin
                    next_state = st_error;          // a late start still wins
                end
            end
            st_cmd55_proc: begin
                if (resp_ok) begin
                    load_r1_status = 1'b1;
                    next_state     = st_cmd55_gap;
                end else begin
                    next_state = st_error;
                end
            end
            st_acmd41_proc: begin
                // busy is looked at before the voltage window
                if (card_busy)     next_state = st_acmd41_retry;
                else if (volt_bad) next_state = st_inactive;
                else               next_state = st_acmd41_gap;
            end
            st_cmd2_proc: begin
                if (resp_ok) begin
                    load_cid   = 1'b1;
                    next_state = st_cmd2_gap;
                end else begin
                    next_state = st_error;
                end
            end
            st_cmd3_proc: begin
                if (resp_ok) begin
                    load_rca       = 1'b1;
                    load_r6_status = 1'b1;
                    next_state     = st_cmd3_gap;
                end else begin
                    next_state = st_error;
                end
            end
            st_cmd55_gap:    if (gap_done) next_state = st_acmd41_send;
            st_acmd41_gap:   if (gap_done) next_state = st_cmd2_send;
            st_acmd41_retry: if (gap_done) next_state = st_cmd55_send;
            st_cmd2_gap:     if (gap_done) next_state = st_cmd3_send;
            st_cmd3_gap:     if (gap_done) next_state = st_standby;
            st_standby:      next_state = st_standby;
            st_error:        next_state = st_inactive;
            st_inactive:     next_state = st_inactive;
            default:         next_state = st_inactive;
        endcase
        // receiver CRC failure overrides, identification result is final
        if (crc_response_err && state != st_standby && state != st_inactive) begin
            next_state = st_error;
        end
    end

    // line controls decoded from the state alone
    always_comb begin
        send_en     = 1'b0;
        r2_response = 1'b0;
        r3_response = 1'b0;
        timer_mode  = timer_off;
        case (state)
            st_cmd55_send, st_acmd41_send, st_cmd2_send, st_cmd3_send: send_en = 1'b1;
            st_cmd55_receive, st_cmd3_receive: timer_mode = timer_listen;
            st_acmd41_receive: begin
                timer_mode  = timer_listen;
                r3_response = 1'b1;
            end
            st_cmd2_receive: begin
                timer_mode  = timer_listen;
                r2_response = 1'b1;
            end
            st_cmd55_gap, st_acmd41_gap, st_acmd41_retry, st_cmd2_gap, st_cmd3_gap: begin
                timer_mode = timer_gap;
            end
            default: ;
        endcase
    end

    // frame and response kind held for the whole command
    always_comb begin
        cmd_idx   = `SD_CMD0;   // idle frame, never sent
        cmd_arg   = '0;
        resp_kind = resp_r1;
        case (state)
            st_cmd55_send, st_cmd55_wait, st_cmd55_receive, st_cmd55_proc, st_cmd55_gap: begin
                cmd_idx = `SD_CMD55;
                cmd_arg = {rca, 16'h0000};
            end
            st_acmd41_send, st_acmd41_wait, st_acmd41_receive, st_acmd41_proc,
            st_acmd41_gap, st_acmd41_retry: begin
                cmd_idx   = `SD_ACMD41;
                cmd_arg   = {1'b0, host_ocr[30:0]};   // busy bit cleared
                resp_kind = resp_r3;
            end
            st_cmd2_send, st_cmd2_wait, st_cmd2_receive, st_cmd2_proc, st_cmd2_gap: begin
                cmd_idx   = `SD_CMD2;
                resp_kind = resp_r2;
            end
            st_cmd3_send, st_cmd3_wait, st_cmd3_receive, st_cmd3_proc, st_cmd3_gap: begin
                cmd_idx   = `SD_CMD3;
                resp_kind = resp_r6;
            end
            default: ;
        endcase
    end

    assign send_cmd_content = {cmd_idx, cmd_arg};
    assign init_done        = (state == st_standby);
    assign init_failed      = (state == st_error) || (state == st_inactive);

endmodule

// ==== design/sd_init_pkg.sv ====
`include "sd_init_consts.svh"

package sd_init_pkg;

    typedef logic [5:0]   cmd_index_t;
    typedef logic [31:0]  cmd_arg_t;
    typedef logic [37:0]  cmd_frame_t;     // index above argument
    typedef logic [126:0] response_t;
    typedef logic [126:0] cid_t;
    typedef logic [15:0]  rca_t;
    typedef logic [31:0]  card_status_t;

    typedef enum logic [1:0] {resp_r1, resp_r2, resp_r3, resp_r6} resp_kind_t;

    typedef enum logic [1:0] {timer_off, timer_listen, timer_gap} timer_mode_t;

    // per command the order send, wait, receive, proc, gap is relied on
    typedef enum logic [4:0] {
        st_wait_card,
        st_cmd55_send, st_cmd55_wait, st_cmd55_receive, st_cmd55_proc, st_cmd55_gap,
        st_acmd41_send, st_acmd41_wait, st_acmd41_receive, st_acmd41_proc, st_acmd41_gap,
        st_cmd2_send, st_cmd2_wait, st_cmd2_receive, st_cmd2_proc, st_cmd2_gap,
        st_cmd3_send, st_cmd3_wait, st_cmd3_receive, st_cmd3_proc, st_cmd3_gap,
        st_acmd41_retry,    // gap after a busy OCR, back to CMD55
        st_standby,
        st_error,
        st_inactive
    } init_state_t;

endpackage

// ==== design/sd_init_top.sv ====
module sd_init_top (
    input  logic                       ex_clk,
    input  logic                       reset,
    input  logic                       sd_cd_pin,
    input  logic                       sd_sending,
    input  logic                       sd_send_finished,
    input  logic                       sd_receive_started,
    input  logic                       sd_receive_finished,
    input  logic                       crc_loaded,
    input  logic                       crc_response_err,
    input  sd_init_pkg::response_t     response,
    input  sd_init_pkg::card_status_t  host_ocr,
    output logic                       send_en,
    output logic                       receive_en,
    output sd_init_pkg::cmd_frame_t    send_cmd_content,
    output logic                       r2_response,
    output logic                       r3_response,
    output logic                       init_done,
    output logic                       init_failed,
    output sd_init_pkg::cid_t          cid,
    output sd_init_pkg::rca_t          rca,
    output sd_init_pkg::card_status_t  card_status
);
    import sd_init_pkg::*;

    logic        timed_out;
    logic        gap_done;
    logic        resp_ok;
    logic        card_busy;
    logic        volt_bad;
    logic        load_cid;
    logic        load_rca;
    logic        load_r1_status;
    logic        load_r6_status;
    resp_kind_t  resp_kind;
    timer_mode_t timer_mode;

    sd_init_fsm u_fsm (
        .ex_clk              (ex_clk),
        .reset               (reset),
        .sd_cd_pin           (sd_cd_pin),
        .sd_sending          (sd_sending),
        .sd_send_finished    (sd_send_finished),
        .sd_receive_started  (sd_receive_started),
        .sd_receive_finished (sd_receive_finished),
        .crc_loaded          (crc_loaded),
        .crc_response_err    (crc_response_err),
        .timed_out           (timed_out),
        .gap_done            (gap_done),
        .resp_ok             (resp_ok),
        .card_busy           (card_busy),
        .volt_bad            (volt_bad),
        .rca                 (rca),
        .host_ocr            (host_ocr),
        .send_en             (send_en),
        .send_cmd_content    (send_cmd_content),
        .receive_en          (receive_en),
        .r2_response         (r2_response),
        .r3_response         (r3_response),
        .init_done           (init_done),
        .init_failed         (init_failed),
        .resp_kind           (resp_kind),
        .timer_mode          (timer_mode),
        .load_cid            (load_cid),
        .load_rca            (load_rca),
        .load_r1_status      (load_r1_status),
        .load_r6_status      (load_r6_status)
    );

    response_checker u_checker (
        .response  (response),
        .resp_kind (resp_kind),
        .resp_ok   (resp_ok),
        .card_busy (card_busy),
        .volt_bad  (volt_bad)
    );

    gap_timeout_timer u_timer (
        .ex_clk             (ex_clk),
        .reset              (reset),
        .timer_mode         (timer_mode),
        .sd_receive_started (sd_receive_started),
        .timed_out          (timed_out),
        .gap_done           (gap_done)
    );

    card_regs u_regs (
        .ex_clk         (ex_clk),
        .reset          (reset),
        .response       (response),
        .load_cid       (load_cid),
        .load_rca       (load_rca),
        .load_r1_status (load_r1_status),
        .load_r6_status (load_r6_status),
        .cid            (cid),
        .rca            (rca),
        .card_status    (card_status)
    );

endmodule

// ==== flist.f ====
+incdir+design
design/sd_init_pkg.sv
design/response_checker.sv
design/gap_timeout_timer.sv
design/card_regs.sv
design/sd_init_fsm.sv
design/sd_init_top.sv
verification/sd_init_assertions.sv
verification/sd_init_tb.sv

// ==== verification/sd_init_assertions.sv ====
module sd_init_assertions (
    input  logic                     ex_clk,
    input  logic                     reset,
    input  logic                     send_en,
    input  logic                     sd_sending,
    input  sd_init_pkg::cmd_frame_t  send_cmd_content,
    input  logic                     receive_en,
    input  logic                     init_done,
    input  logic                     init_failed
);
    timeunit 1ns;
    timeprecision 1ps;

    // frame stays on the line until the transmitter picks it up
    send_held: assert property (@(posedge ex_clk) disable iff (reset)
        send_en && !sd_sending |=> send_en && $stable(send_cmd_content))
        else $error("send_en dropped or frame changed before sd_sending");

    send_release: assert property (@(posedge ex_clk) disable iff (reset)
        send_en && sd_sending |=> !send_en)   // released right after pickup
        else $error("send_en still high after sd_sending was seen");

    rx_pulse: assert property (@(posedge ex_clk) disable iff (reset)
        receive_en |=> !receive_en)
        else $error("receive_en held longer than one cycle");

    // standby is final until the next reset
    done_sticky: assert property (@(posedge ex_clk) disable iff (reset)
        init_done |=> init_done)
        else $error("init_done dropped without a reset");

    failed_sticky: assert property (@(posedge ex_clk) disable iff (reset)
        init_failed |=> init_failed)
        else $error("init_failed dropped without a reset");

endmodule

// ==== verification/sd_init_tb.sv ====
`include "sd_init_consts.svh"

module sd_init_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import sd_init_pkg::*;

    localparam int NUM_TESTS    = 6;
    localparam int WORST_CYCLES = 2000;   // per test

    logic         ex_clk;
    logic         reset;
    logic         sd_cd_pin;
    logic         sd_sending;
    logic         sd_send_finished;
    logic         sd_receive_started;
    logic         sd_receive_finished;
    logic         crc_loaded;
    logic         crc_response_err;
    response_t    response;
    card_status_t host_ocr;
    logic         send_en;
    logic         receive_en;
    cmd_frame_t   send_cmd_content;
    logic         r2_response;
    logic         r3_response;
    logic         init_done;
    logic         init_failed;
    cid_t         cid;
    rca_t         rca;
    card_status_t card_status;

    // scenario of the running test
    int           busy_count;
    int           busy_left;
    bit           r1_err;
    bit           volt_err;
    bit           drop_start;
    bit           crc_err;
    card_status_t ocr_value;
    card_status_t r1_pay;
    cid_t         card_cid;
    rca_t         card_rca;
    logic [15:0]  r6_low;

    // expected and observed results
    cmd_frame_t   exp_frames[$];
    cmd_frame_t   got_frames[$];
    cid_t         exp_cid;
    rca_t         exp_rca;
    card_status_t exp_status;
    logic         exp_done;
    logic         exp_failed;

    bit           check_req;
    int           error_count;
    int           test_errors;
    int           test_num;
    int           failed_tests;

    sd_init_top dut0 (.*);

    bind sd_init_top sd_init_assertions u_assertions (
        .ex_clk           (ex_clk),
        .reset            (reset),
        .send_en          (send_en),
        .sd_sending       (sd_sending),
        .send_cmd_content (send_cmd_content),
        .receive_en       (receive_en),
        .init_done        (init_done),
        .init_failed      (init_failed)
    );

    initial begin
        ex_clk = 1'b0;
        forever #4 ex_clk = ~ex_clk;
    end

    task automatic check_value(input string what, input logic [126:0] got,
                               input logic [126:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, got, exp);
            error_count++;
            test_errors++;
        end
    endtask

    // expected frames and final outputs of a scenario
    function automatic void predict_run();
        int i;
        exp_frames.delete();
        exp_cid    = '0;
        exp_rca    = '0;
        exp_status = '0;
        exp_done   = 1'b0;
        exp_failed = 1'b1;
        for (i = 0; i <= busy_count; i++) begin
            exp_frames.push_back({`SD_CMD55, 32'h0});   // address still zero
            if (r1_err) return;
            exp_status = r1_pay;
            exp_frames.push_back({`SD_ACMD41, 1'b0, ocr_value[30:0]});
        end
        if (volt_err) return;
        exp_frames.push_back({`SD_CMD2, 32'h0});
        if (drop_start) return;
        exp_cid = card_cid;
        exp_frames.push_back({`SD_CMD3, 32'h0});
        if (crc_err) return;
        exp_rca         = card_rca;
        exp_status      = '0;
        exp_status[23]  = r6_low[15];
        exp_status[22]  = r6_low[14];
        exp_status[19]  = r6_low[13];
        exp_status[12:0] = r6_low[12:0];
        exp_done   = 1'b1;
        exp_failed = 1'b0;
    endfunction

    // card answer for one command, filler bits random
    function automatic response_t build_response(input cmd_index_t idx);
        logic [127:0] wide;
        response_t    resp;
        card_status_t pay;
        wide = {$urandom(), $urandom(), $urandom(), $urandom()};
        resp = wide[126:0];
        pay  = $urandom();
        case (idx)
            `SD_CMD55: begin
                pay = r1_err ? (r1_pay | 32'h0200_0000) : r1_pay;
                resp[`SD_IDX_MSB:`SD_IDX_LSB] = `SD_CMD55;
            end
            `SD_ACMD41: begin
                pay[`SD_OCR_BUSY_BIT] = (busy_left > 0);
                pay[`SD_VOLT_MSB:`SD_VOLT_LSB] = volt_err ? 2'b01 : 2'b00;
                if (busy_left > 0) busy_left--;
            end
            `SD_CMD3: begin
                pay = {card_rca, r6_low};
                resp[`SD_IDX_MSB:`SD_IDX_LSB] = `SD_CMD3;
            end
            default: ;
        endcase
        resp[`SD_PAY_MSB:`SD_PAY_LSB] = pay;
        if (idx == `SD_CMD2) resp = card_cid;
        return resp;
    endfunction

    task automatic serve_command(input cmd_index_t idx);
        repeat ($urandom_range(1, 3)) @(posedge ex_clk);
        sd_sending <= 1'b1;
        @(posedge ex_clk);
        sd_sending <= 1'b0;
        repeat ($urandom_range(1, 3)) @(posedge ex_clk);
        sd_send_finished <= 1'b1;
        do @(posedge ex_clk); while (!receive_en);
        sd_send_finished <= 1'b0;
        if (idx == `SD_CMD2 && drop_start) return;   // silent card
        repeat ($urandom_range(0, int'(`SD_TIMEOUT_LIMIT) - 1)) @(posedge ex_clk);
        sd_receive_started <= 1'b1;
        @(posedge ex_clk);
        check_value("r2_response", 127'(r2_response), 127'(idx == `SD_CMD2));
        check_value("r3_response", 127'(r3_response), 127'(idx == `SD_ACMD41));
        sd_receive_started <= 1'b0;
        if (idx == `SD_CMD3 && crc_err) begin
            crc_response_err <= 1'b1;
            @(posedge ex_clk);
            crc_response_err <= 1'b0;
            return;
        end
        response <= build_response(idx);
        if (idx == `SD_ACMD41) sd_receive_finished <= 1'b1;   // R3 has no CRC
        else                   crc_loaded <= 1'b1;
        @(posedge ex_clk);
        sd_receive_finished <= 1'b0;
        crc_loaded          <= 1'b0;
    endtask

    initial begin : card_model
        forever begin
            @(posedge ex_clk);
            if (send_en) serve_command(send_cmd_content[37:32]);
        end
    end

    initial begin : compare_proc
        logic send_seen;
        int   i;
        send_seen = 1'b0;
        forever begin
            @(posedge ex_clk);
            if (check_req) begin
                check_value("frame count", 127'(got_frames.size()), 127'(exp_frames.size()));
                for (i = 0; i < exp_frames.size() && i < got_frames.size(); i++) begin
                    check_value($sformatf("frame %0d", i), 127'(got_frames[i]),
                                127'(exp_frames[i]));
                end
                check_value("cid", cid, exp_cid);
                check_value("rca", 127'(rca), 127'(exp_rca));
                check_value("card_status", 127'(card_status), 127'(exp_status));
                check_value("init_done", 127'(init_done), 127'(exp_done));
                check_value("init_failed", 127'(init_failed), 127'(exp_failed));
                check_req = 1'b0;
            end else if (send_en && !send_seen) begin
                got_frames.push_back(send_cmd_content);
            end
            send_seen = send_en;
        end
    end

    task automatic run_test(input string name, input int busy, input bit e_r1,
                            input bit e_volt, input bit e_drop, input bit e_crc);
        int waited;
        test_num++;
        test_errors = 0;
        busy_count  = busy;
        busy_left   = busy;
        r1_err      = e_r1;
        volt_err    = e_volt;
        drop_start  = e_drop;
        crc_err     = e_crc;
        ocr_value   = $urandom();
        r1_pay      = $urandom() & ~`SD_R1_ERR_MASK;
        card_cid    = build_response(`SD_CMD0);
        card_rca    = 16'($urandom_range(1, 65535));
        r6_low      = 16'($urandom()) & 16'h01ff;   // status error bits clear
        predict_run();
        @(posedge ex_clk);
        reset     <= 1'b1;
        sd_cd_pin <= 1'b0;
        host_ocr  <= ocr_value;
        repeat (3) @(posedge ex_clk);
        reset <= 1'b0;
        got_frames.delete();
        repeat (2) @(posedge ex_clk);
        sd_cd_pin <= 1'b1;
        waited = 0;
        while (!(init_done || init_failed) && waited < WORST_CYCLES) begin
            @(posedge ex_clk);
            waited++;
        end
        if (!(init_done || init_failed)) begin
            $display("test %0d: sequencer reached neither standby nor failure in %0d cycles",
                     test_num, WORST_CYCLES);
            error_count++;
            test_errors++;
        end
        repeat (30) @(posedge ex_clk);   // room for a stray frame
        check_req = 1'b1;
        wait (check_req == 1'b0);
        if (test_errors != 0) failed_tests++;
        $display("test %0d %s: %s", test_num, name, (test_errors == 0) ? "pass" : "fail");
    endtask

    initial begin : watchdog
        repeat (NUM_TESTS * WORST_CYCLES) @(posedge ex_clk);
        $display("watchdog: run did not complete within %0d cycles", NUM_TESTS * WORST_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        reset               = 1'b1;
        sd_cd_pin           = 1'b0;
        sd_sending          = 1'b0;
        sd_send_finished    = 1'b0;
        sd_receive_started  = 1'b0;
        sd_receive_finished = 1'b0;
        crc_loaded          = 1'b0;
        crc_response_err    = 1'b0;
        response            = '0;
        host_ocr            = '0;
        check_req           = 1'b0;
        void'($urandom(32'h598b_7ea5));
        run_test("ready card", 0, 1'b0, 1'b0, 1'b0, 1'b0);
        run_test("busy card", $urandom_range(1, 4), 1'b0, 1'b0, 1'b0, 1'b0);
        run_test("no start after CMD2", 0, 1'b0, 1'b0, 1'b1, 1'b0);
        run_test("R1 error on CMD55", 0, 1'b1, 1'b0, 1'b0, 1'b0);
        run_test("voltage mismatch", 0, 1'b0, 1'b1, 1'b0, 1'b0);
        run_test("CRC error on CMD3", 0, 1'b0, 1'b0, 1'b0, 1'b1);
        $display("%0d tests, %0d failed, %0d errors", test_num, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
